/* tb.f */
+incdir+verilog
verilog/axis_in_pkg.sv
verilog/axis_in_packer.sv
verilog/axis_in_cdc_fifo.sv
verilog/axis_in_regs.sv
verilog/axis_in_top.sv
tb/tb_clkgen.sv
tb/tb_axis_in.sv

/* tb/tb_axis_in.sv */
`default_nettype none

`include "axis_in_params.svh"

module tb_axis_in;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_CYCLES = 20000;

   logic                     clk_i;
   logic                     axis_clk_i;
   logic                     arst_n_i;
   logic                     axis_tvalid_i;
   logic [`TDATA_W-1:0]      axis_tdata_i;
   logic                     axis_tlast_i;
   logic                     axis_tready_o;
   logic [`CPU_ADDR_W-1:0]   cpu_addr_i;
   logic [`DATA_W-1:0]       cpu_wdata_i;
   logic                     cpu_we_i;
   logic                     cpu_re_i;
   logic [`DATA_W-1:0]       cpu_rdata_o;
   logic                     cpu_rvalid_o;
   logic                     sys_tvalid_o;
   logic [`DATA_W-1:0]       sys_tdata_o;
   logic                     sys_tready_i;
   logic                     interrupt_o;

   logic [15:0]              lfsr_q = 16'd30939;
   logic [`TDATA_W-1:0]      frame_bytes[$];
   // Expected words in arrival order for CPU reads and stream output alike
   logic [`DATA_W-1:0]       exp_q[$];
   logic [`CPU_ADDR_W-1:0]   rd_addr;
   logic                     ready_rand = 1'b0;
   logic                     stalled = 1'b0;
   logic [`DATA_W-1:0]       stall_word;
   int                       beats_sent = 0;
   int                       cycles = 0;

   tb_clkgen #(.PERIOD(8.0), .PHASE(0.0)) clk_gen (.clk_o(clk_i));
   tb_clkgen #(.PERIOD(8.0), .PHASE(3.0)) axis_clk_gen (.clk_o(axis_clk_i));

   axis_in_top dut0 (
      .clk_i        (clk_i),
      .axis_clk_i   (axis_clk_i),
      .arst_n_i     (arst_n_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .cpu_addr_i   (cpu_addr_i),
      .cpu_wdata_i  (cpu_wdata_i),
      .cpu_we_i     (cpu_we_i),
      .cpu_re_i     (cpu_re_i),
      .cpu_rdata_o  (cpu_rdata_o),
      .cpu_rvalid_o (cpu_rvalid_o),
      .sys_tvalid_o (sys_tvalid_o),
      .sys_tdata_o  (sys_tdata_o),
      .sys_tready_i (sys_tready_i),
      .interrupt_o  (interrupt_o)
   );

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   // Byte k of a word sits in lane k and bytes past the frame end read as zero
   function automatic logic [`DATA_W-1:0] packed_word(input logic [`TDATA_W-1:0] bytes[$],
                                                      input int idx);
      logic [`DATA_W-1:0] w;
      w = '0;
      for (int k = 0; k < `LANES; k++) begin
         if (idx * `LANES + k < bytes.size()) begin
            w[k*`TDATA_W +: `TDATA_W] = bytes[idx*`LANES + k];
         end
      end
      return w;
   endfunction

   function automatic logic [`DATA_W-1:0] pop_expected();
      if (exp_q.size() == 0) begin
         return '0;
      end
      return exp_q.pop_front();
   endfunction

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp)
         else report_failure($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic write_reg(input logic [`CPU_ADDR_W-1:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      cpu_addr_i  <= addr;
      cpu_wdata_i <= data;
      cpu_we_i    <= 1'b1;
      @(posedge clk_i);
      cpu_we_i    <= 1'b0;
   endtask

   task automatic read_reg(input logic [`CPU_ADDR_W-1:0] addr, output logic [31:0] data);
      @(posedge clk_i);
      cpu_addr_i <= addr;
      cpu_re_i   <= 1'b1;
      @(posedge clk_i);
      cpu_re_i   <= 1'b0;
      do @(negedge clk_i); while (!cpu_rvalid_o);
      data = cpu_rdata_o;
   endtask

   task automatic check_reg(input logic [`CPU_ADDR_W-1:0] addr, input logic [31:0] exp,
                            input string what);
      logic [31:0] rd;
      read_reg(addr, rd);
      check_value(what, rd, exp);
   endtask

   task automatic wait_status(input int bit_idx, input logic val);
      logic [31:0] st;
      do read_reg(`REG_STATUS, st); while (st[bit_idx] != val);
   endtask

   task automatic wait_level(input int n);
      logic [31:0] lvl;
      int          tries;
      tries = 0;
      do begin
         read_reg(`REG_LEVEL, lvl);
         tries++;
      end while (lvl != n && tries < 200);
      check_value("LEVEL", lvl, n);
   endtask

   // One idle cycle lets the prefetch stage load the next word
   task automatic read_data_word();
      logic [31:0] rd;
      wait_status(`STAT_EMPTY_BIT, 1'b0);
      @(posedge clk_i);
      read_reg(`REG_DATA, rd);
   endtask

   task automatic make_frame(input int len);
      frame_bytes.delete();
      for (int i = 0; i < len; i++) begin
         frame_bytes.push_back(lfsr_bits(`TDATA_W));
      end
      for (int w = 0; w < (len + `LANES - 1) / `LANES; w++) begin
         exp_q.push_back(packed_word(frame_bytes, w));
      end
   endtask

   task automatic send_beats(input logic [`TDATA_W-1:0] bytes[$]);
      @(posedge axis_clk_i);
      for (int i = 0; i < bytes.size(); i++) begin
         axis_tvalid_i <= 1'b1;
         axis_tdata_i  <= bytes[i];
         axis_tlast_i  <= (i == bytes.size() - 1);
         do @(negedge axis_clk_i); while (!axis_tready_o);
         @(posedge axis_clk_i);
         beats_sent = beats_sent + 1;
      end
      axis_tvalid_i <= 1'b0;
      axis_tlast_i  <= 1'b0;
   endtask

   task automatic soft_reset();
      write_reg(`REG_CTRL, 32'h1 << `CTRL_SRST_BIT);
      repeat (8) @(posedge clk_i);
      write_reg(`REG_CTRL, 32'h0);
      repeat (4) @(posedge clk_i);
      exp_q.delete();
   endtask

   always @(posedge clk_i) begin
      if (ready_rand) begin
         sys_tready_i <= (lfsr_bits(1) != 0);
      end
   end

   // Address of the read whose data returns with the next rvalid
   always @(posedge clk_i) begin
      if (cpu_re_i) begin
         rd_addr <= cpu_addr_i;
      end
   end

   // Outputs are stable at the falling edge between two rising edges
   always @(negedge clk_i) begin : compare
      logic [`DATA_W-1:0] exp_w;
      if (stalled) begin
         assert (sys_tvalid_o && sys_tdata_o == stall_word)
            else report_failure($sformatf("ERR %0t: stalled word %h not held", $time,
                                          stall_word));
      end
      if (sys_tvalid_o && sys_tready_i) begin
         exp_w = pop_expected();
         assert (sys_tdata_o == exp_w)
            else report_failure($sformatf("ERR %0t: stream word got %h expected %h", $time,
                                          sys_tdata_o, exp_w));
      end
      if (cpu_rvalid_o && rd_addr == `REG_DATA) begin
         exp_w = pop_expected();
         assert (cpu_rdata_o == exp_w)
            else report_failure($sformatf("ERR %0t: DATA read got %h expected %h", $time,
                                          cpu_rdata_o, exp_w));
      end
      stalled    = sys_tvalid_o && !sys_tready_i;
      stall_word = sys_tdata_o;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         report_failure("Timeout: the tests did not finish within 20000 clock cycles");
      end
   end

   initial begin : main
      logic [31:0] rd;
      int          len;
      arst_n_i      = 1'b0;
      axis_tvalid_i = 1'b0;
      axis_tdata_i  = '0;
      axis_tlast_i  = 1'b0;
      cpu_addr_i    = '0;
      cpu_wdata_i   = '0;
      cpu_we_i      = 1'b0;
      cpu_re_i      = 1'b0;
      sys_tready_i  = 1'b0;
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      repeat (2) @(posedge clk_i);

      // Idle state out of reset
      @(negedge clk_i);
      check_value("tready after reset", axis_tready_o, 0);
      check_value("sys_tvalid after reset", sys_tvalid_o, 0);
      check_value("interrupt after reset", interrupt_o, 0);
      check_value("rvalid after reset", cpu_rvalid_o, 0);
      check_reg(`REG_STATUS, 32'h1, "STATUS after reset");

      // CSR mode, one short frame
      write_reg(`REG_CTRL, 32'h1);
      len = 1 + lfsr_bits(8) % 13;
      make_frame(len);
      send_beats(frame_bytes);
      wait_status(`STAT_EOF_BIT, 1'b1);
      check_reg(`REG_NBEATS, len, "NBEATS");
      @(posedge axis_clk_i);
      axis_tvalid_i <= 1'b1;
      axis_tdata_i  <= lfsr_bits(8);
      repeat (4) @(negedge axis_clk_i);
      check_value("tready after tlast", axis_tready_o, 0);
      @(posedge axis_clk_i);
      axis_tvalid_i <= 1'b0;
      repeat ((len + 3) / 4) read_data_word();
      // Queue is empty now and zero is expected
      read_reg(`REG_DATA, rd);
      soft_reset();

      // Level and interrupt
      write_reg(`REG_CTRL, 32'h1);
      write_reg(`REG_THRESH, 32'd3);
      make_frame(16);
      send_beats(frame_bytes);
      wait_status(`STAT_EOF_BIT, 1'b1);
      wait_level(4);
      @(negedge clk_i);
      check_value("interrupt at level 4", interrupt_o, 1);
      read_data_word();
      read_data_word();
      check_reg(`REG_LEVEL, 32'd2, "LEVEL after two reads");
      @(negedge clk_i);
      check_value("interrupt at level 2", interrupt_o, 0);
      soft_reset();

      // Full FIFO stalls the input with 16 stored plus one held
      write_reg(`REG_CTRL, 32'h1);
      make_frame(72);
      beats_sent = 0;
      fork
         send_beats(frame_bytes);
         begin
            wait_level(17);
            @(negedge axis_clk_i);
            check_value("tready when full", axis_tready_o, 0);
            check_value("beats accepted when full", beats_sent, 68);
            check_reg(`REG_STATUS, 32'h2, "STATUS when full");
            repeat (18) read_data_word();
         end
      join
      soft_reset();

      // System stream with random back-pressure
      write_reg(`REG_CTRL, 32'h3);
      for (int f = 0; f < 3; f++) begin
         make_frame(1 + lfsr_bits(8) % 24);
         if (f == 0) begin
            @(negedge clk_i);
            ready_rand = 1'b1;
         end
         send_beats(frame_bytes);
      end
      while (exp_q.size() != 0) @(posedge clk_i);
      ready_rand = 1'b0;
      soft_reset();

      // Soft reset clears stored words, status and counters
      write_reg(`REG_CTRL, 32'h1);
      make_frame(9);
      send_beats(frame_bytes);
      wait_status(`STAT_EOF_BIT, 1'b1);
      soft_reset();
      check_reg(`REG_STATUS, 32'h1, "STATUS after soft reset");
      check_reg(`REG_LEVEL, 32'h0, "LEVEL after soft reset");
      check_reg(`REG_NBEATS, 32'h0, "NBEATS after soft reset");

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
   parameter real PERIOD = 8.0,
   parameter real PHASE  = 0.0
) (
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // Phase delays the first edge only
   initial begin
      clk_o = 1'b0;
      #(PHASE);
      forever #(PERIOD / 2.0) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

/* verilog/axis_in_cdc_fifo.sv */
`default_nettype none

`include "axis_in_params.svh"

module axis_in_cdc_fifo (
   input  wire                             w_clk_i,
   input  wire                             w_rst_i,
   input  wire                             push_i,
   input  wire axis_in_pkg::axis_word_u    w_word_i,
   output logic                            w_full_o,
   input  wire                             r_clk_i,
   input  wire                             r_rst_i,
   input  wire                             pop_i,
   output axis_in_pkg::axis_word_u         r_word_o,
   output logic                            r_empty_o,
   output logic                            r_full_o,
   output logic [`FIFO_ADDR_W:0]           r_level_o,
   input  wire                             arst_n_i
);

   localparam int AW    = `FIFO_ADDR_W;
   localparam int DEPTH = 1 << AW;

   axis_in_pkg::axis_word_u mem [DEPTH];

   logic [AW:0] w_bin_q;
   logic [AW:0] w_gray_q;
   logic [AW:0] w_bin_nxt;
   logic [AW:0] w_rgray_m_q;
   logic [AW:0] w_rgray_s_q;
   logic [AW:0] r_bin_q;
   logic [AW:0] r_gray_q;
   logic [AW:0] r_bin_nxt;
   logic [AW:0] r_wgray_m_q;
   logic [AW:0] r_wgray_s_q;
   logic [AW:0] r_wbin;
   logic        do_push;
   logic        do_pop;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write side
   assign w_full_o  = (w_gray_q == {~w_rgray_s_q[AW:AW-1], w_rgray_s_q[AW-2:0]});
   assign do_push   = push_i && !w_full_o;
   assign w_bin_nxt = w_bin_q + 1'b1;

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_bin_q     <= '0;
         w_gray_q    <= '0;
         w_rgray_m_q <= '0;
         w_rgray_s_q <= '0;
      end else begin
         w_rgray_m_q <= r_gray_q;
         w_rgray_s_q <= w_rgray_m_q;
         if (w_rst_i) begin
            w_bin_q  <= '0;
            w_gray_q <= '0;
         end else if (do_push) begin
            w_bin_q  <= w_bin_nxt;
            w_gray_q <= bin2gray(w_bin_nxt);
         end
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (do_push) begin
         mem[w_bin_q[AW-1:0]] <= w_word_i;
      end
   end

   // Read side, level from the synchronized write pointer
   assign r_empty_o = (r_gray_q == r_wgray_s_q);
   assign do_pop    = pop_i && !r_empty_o;
   assign r_bin_nxt = r_bin_q + 1'b1;
   assign r_wbin    = gray2bin(r_wgray_s_q);
   assign r_level_o = r_wbin - r_bin_q;
   assign r_full_o  = r_level_o[AW];

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_bin_q     <= '0;
         r_gray_q    <= '0;
         r_wgray_m_q <= '0;
         r_wgray_s_q <= '0;
      end else begin
         r_wgray_m_q <= w_gray_q;
         r_wgray_s_q <= r_wgray_m_q;
         if (r_rst_i) begin
            r_bin_q  <= '0;
            r_gray_q <= '0;
         end else if (do_pop) begin
            r_bin_q  <= r_bin_nxt;
            r_gray_q <= bin2gray(r_bin_nxt);
         end
      end
   end

   // Data valid the cycle after the pop
   always_ff @(posedge r_clk_i) begin
      if (do_pop) begin
         r_word_o <= mem[r_bin_q[AW-1:0]];
      end
   end

   a_no_push_full: assert property (
      @(posedge w_clk_i) disable iff (!arst_n_i) !(push_i && w_full_o)
   );

   a_no_pop_empty: assert property (
      @(posedge r_clk_i) disable iff (!arst_n_i) !(pop_i && r_empty_o)
   );

endmodule

`default_nettype wire

/* verilog/axis_in_packer.sv */
`default_nettype none

`include "axis_in_params.svh"

module axis_in_packer (
   input  wire                        axis_clk_i,
   input  wire                        arst_n_i,
   input  wire                        ctrl_en_i,
   input  wire                        ctrl_mode_i,
   input  wire                        ctrl_srst_i,
   input  wire                        axis_tvalid_i,
   input  wire  [`TDATA_W-1:0]        axis_tdata_i,
   input  wire                        axis_tlast_i,
   output logic                       axis_tready_o,
   input  wire                        w_full_i,
   output logic                       push_o,
   output axis_in_pkg::axis_word_u    push_word_o,
   output logic [`DATA_W-1:0]         nbeats_o,
   output logic                       eof_det_o,
   output logic                       srst_o
);

   localparam int LANE_W = $clog2(`LANES);

   logic [2:0]                ctrl_lvl;
   logic [2:0]                ctrl_meta_q;
   logic [2:0]                ctrl_sync_q;
   logic                      en_s;
   logic                      mode_s;
   logic [LANE_W-1:0]         lane_q;
   axis_in_pkg::axis_word_u   word_q;
   axis_in_pkg::axis_word_u   word_nxt;
   logic                      beat;

   // Control levels from the system domain pass two flops each
   assign ctrl_lvl[`CTRL_EN_BIT]   = ctrl_en_i;
   assign ctrl_lvl[`CTRL_MODE_BIT] = ctrl_mode_i;
   assign ctrl_lvl[`CTRL_SRST_BIT] = ctrl_srst_i;

   always_ff @(posedge axis_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_meta_q <= '0;
         ctrl_sync_q <= '0;
      end else begin
         ctrl_meta_q <= ctrl_lvl;
         ctrl_sync_q <= ctrl_meta_q;
      end
   end

   assign en_s   = ctrl_sync_q[`CTRL_EN_BIT];
   assign mode_s = ctrl_sync_q[`CTRL_MODE_BIT];
   assign srst_o = ctrl_sync_q[`CTRL_SRST_BIT];

   // In CSR mode a detected end of frame blocks further input
   assign axis_tready_o = en_s && !srst_o && !w_full_i && !(!mode_s && eof_det_o);
   assign beat          = axis_tvalid_i && axis_tready_o;

   // Higher lanes of word_q stay zero and pad a short last word
   always_comb begin
      word_nxt              = word_q;
      word_nxt.lane[lane_q] = axis_tdata_i;
   end

   assign push_word_o = word_nxt;
   assign push_o      = beat && (lane_q == LANE_W'(`LANES - 1) || axis_tlast_i);

   always_ff @(posedge axis_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_q    <= '0;
         word_q    <= '0;
         nbeats_o  <= '0;
         eof_det_o <= 1'b0;
      end else if (srst_o) begin
         lane_q    <= '0;
         word_q    <= '0;
         nbeats_o  <= '0;
         eof_det_o <= 1'b0;
      end else if (beat) begin
         if (push_o) begin
            lane_q <= '0;
            word_q <= '0;
         end else begin
            lane_q <= lane_q + 1'b1;
            word_q <= word_nxt;
         end
         // Count freezes once end of frame is seen with the last beat included
         if (!eof_det_o) begin
            nbeats_o <= nbeats_o + 1'b1;
         end
         if (axis_tlast_i) begin
            eof_det_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/axis_in_params.svh */
`ifndef AXIS_IN_PARAMS_SVH
`define AXIS_IN_PARAMS_SVH

// Stream and word geometry
`define TDATA_W 8
`define DATA_W 32
`define LANES 4
`define FIFO_ADDR_W 4
`define CPU_ADDR_W 3

// CPU register map
`define REG_CTRL 3'd0
`define REG_THRESH 3'd1
`define REG_DATA 3'd2
`define REG_STATUS 3'd3
`define REG_LEVEL 3'd4
`define REG_NBEATS 3'd5

// Control register bits
`define CTRL_EN_BIT 0
`define CTRL_MODE_BIT 1
`define CTRL_SRST_BIT 2

// Status register bits
`define STAT_EMPTY_BIT 0
`define STAT_FULL_BIT 1
`define STAT_EOF_BIT 2

// Above the largest possible level, so no interrupt out of reset
`define THRESH_RST ((1 << `FIFO_ADDR_W) + 2)

`endif

/* verilog/axis_in_pkg.sv */
`default_nettype none

`include "axis_in_params.svh"

package axis_in_pkg;

   // One packed word, seen whole or as byte lanes
   // Lane 0 holds the first beat of the word
   typedef union packed {
      logic [`DATA_W-1:0]                word;
      logic [`LANES-1:0][`TDATA_W-1:0]   lane;
   } axis_word_u;

endpackage

`default_nettype wire

/* verilog/axis_in_regs.sv */
`default_nettype none

`include "axis_in_params.svh"

module axis_in_regs (
   input  wire                             clk_i,
   input  wire                             arst_n_i,
   input  wire  [`CPU_ADDR_W-1:0]          cpu_addr_i,
   input  wire  [`DATA_W-1:0]              cpu_wdata_i,
   input  wire                             cpu_we_i,
   input  wire                             cpu_re_i,
   output logic [`DATA_W-1:0]              cpu_rdata_o,
   output logic                            cpu_rvalid_o,
   output logic                            sys_tvalid_o,
   output logic [`DATA_W-1:0]              sys_tdata_o,
   input  wire                             sys_tready_i,
   output logic                            interrupt_o,
   output logic                            ctrl_en_o,
   output logic                            ctrl_mode_o,
   output logic                            ctrl_srst_o,
   output logic                            pop_o,
   input  wire axis_in_pkg::axis_word_u    r_word_i,
   input  wire                             r_empty_i,
   input  wire                             r_full_i,
   input  wire  [`FIFO_ADDR_W:0]           r_level_i,
   input  wire  [`DATA_W-1:0]              nbeats_i,
   input  wire                             eof_det_i
);

   logic [2:0]              ctrl_q;
   logic [`DATA_W-1:0]      thresh_q;
   logic                    held_q;
   logic                    pend_q;
   logic [`DATA_W-1:0]      hold_word_q;
   logic [1:0]              eof_sync_q;
   logic                    data_rd;
   logic                    consume;
   logic                    st_empty;
   logic [`FIFO_ADDR_W:0]   level;
   logic [`DATA_W-1:0]      rdata_nxt;

   assign ctrl_en_o   = ctrl_q[`CTRL_EN_BIT];
   assign ctrl_mode_o = ctrl_q[`CTRL_MODE_BIT];
   assign ctrl_srst_o = ctrl_q[`CTRL_SRST_BIT];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q   <= '0;
         thresh_q <= `THRESH_RST;
      end else if (cpu_we_i) begin
         case (cpu_addr_i)
            `REG_CTRL:   ctrl_q   <= cpu_wdata_i[2:0];
            `REG_THRESH: thresh_q <= cpu_wdata_i;
            default: ;
         endcase
      end
   end

   // Prefetch stage holds or fetches one word at a time
   assign data_rd = cpu_re_i && (cpu_addr_i == `REG_DATA) && held_q && !ctrl_mode_o;
   assign consume = ctrl_mode_o ? (sys_tvalid_o && sys_tready_i) : data_rd;
   assign pop_o   = !held_q && !pend_q && !r_empty_i && !ctrl_srst_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         held_q <= 1'b0;
         pend_q <= 1'b0;
      end else if (ctrl_srst_o) begin
         held_q <= 1'b0;
         pend_q <= 1'b0;
      end else begin
         pend_q <= pop_o;
         if (pend_q) begin
            held_q <= 1'b1;
         end else if (consume) begin
            held_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (pend_q) begin
         hold_word_q <= r_word_i.word;
      end
   end

   assign sys_tvalid_o = held_q && ctrl_mode_o;
   assign sys_tdata_o  = hold_word_q;

   // A word on its way to the holding register still counts
   assign st_empty    = r_empty_i && !held_q && !pend_q;
   assign level       = r_level_i + (held_q | pend_q);
   assign interrupt_o = `DATA_W'(level) >= thresh_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         eof_sync_q <= '0;
      end else begin
         eof_sync_q <= {eof_sync_q[0], eof_det_i};
      end
   end

   // nbeats is stable once end of frame is seen
   always_comb begin
      rdata_nxt = '0;
      case (cpu_addr_i)
         `REG_DATA: begin
            if (data_rd) begin
               rdata_nxt = hold_word_q;
            end
         end
         `REG_STATUS: begin
            rdata_nxt[`STAT_EMPTY_BIT] = st_empty;
            rdata_nxt[`STAT_FULL_BIT]  = r_full_i;
            rdata_nxt[`STAT_EOF_BIT]   = eof_sync_q[1];
         end
         `REG_LEVEL:  rdata_nxt = `DATA_W'(level);
         `REG_NBEATS: rdata_nxt = nbeats_i;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cpu_rvalid_o <= 1'b0;
      end else begin
         cpu_rvalid_o <= cpu_re_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cpu_re_i) begin
         cpu_rdata_o <= rdata_nxt;
      end
   end

   // Offered word does not change while the sink stalls
   a_sys_data_hold: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      sys_tvalid_o && !sys_tready_i |=> $stable(sys_tdata_o)
   );

endmodule

`default_nettype wire

/* verilog/axis_in_top.sv */
`default_nettype none

`include "axis_in_params.svh"

module axis_in_top (
   input  wire                      clk_i,
   input  wire                      axis_clk_i,
   input  wire                      arst_n_i,
   input  wire                      axis_tvalid_i,
   input  wire  [`TDATA_W-1:0]      axis_tdata_i,
   input  wire                      axis_tlast_i,
   output logic                     axis_tready_o,
   input  wire  [`CPU_ADDR_W-1:0]   cpu_addr_i,
   input  wire  [`DATA_W-1:0]       cpu_wdata_i,
   input  wire                      cpu_we_i,
   input  wire                      cpu_re_i,
   output logic [`DATA_W-1:0]       cpu_rdata_o,
   output logic                     cpu_rvalid_o,
   output logic                     sys_tvalid_o,
   output logic [`DATA_W-1:0]       sys_tdata_o,
   input  wire                      sys_tready_i,
   output logic                     interrupt_o
);

   // Stream domain
   logic                      axis_srst;
   logic                      push;
   axis_in_pkg::axis_word_u   push_word;
   logic                      w_full;
   logic [`DATA_W-1:0]        nbeats;
   logic                      eof_det;

   // System domain
   logic                      ctrl_en;
   logic                      ctrl_mode;
   logic                      ctrl_srst;
   logic                      pop;
   axis_in_pkg::axis_word_u   r_word;
   logic                      r_empty;
   logic                      r_full;
   logic [`FIFO_ADDR_W:0]     r_level;

   axis_in_packer packer0 (
      .axis_clk_i   (axis_clk_i),
      .arst_n_i     (arst_n_i),
      .ctrl_en_i    (ctrl_en),
      .ctrl_mode_i  (ctrl_mode),
      .ctrl_srst_i  (ctrl_srst),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .w_full_i     (w_full),
      .push_o       (push),
      .push_word_o  (push_word),
      .nbeats_o     (nbeats),
      .eof_det_o    (eof_det),
      .srst_o       (axis_srst)
   );

   axis_in_cdc_fifo fifo0 (
      .w_clk_i  (axis_clk_i),
      .w_rst_i  (axis_srst),
      .push_i   (push),
      .w_word_i (push_word),
      .w_full_o (w_full),
      .r_clk_i  (clk_i),
      .r_rst_i  (ctrl_srst),
      .pop_i    (pop),
      .r_word_o (r_word),
      .r_empty_o(r_empty),
      .r_full_o (r_full),
      .r_level_o(r_level),
      .arst_n_i (arst_n_i)
   );

   axis_in_regs regs0 (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cpu_addr_i  (cpu_addr_i),
      .cpu_wdata_i (cpu_wdata_i),
      .cpu_we_i    (cpu_we_i),
      .cpu_re_i    (cpu_re_i),
      .cpu_rdata_o (cpu_rdata_o),
      .cpu_rvalid_o(cpu_rvalid_o),
      .sys_tvalid_o(sys_tvalid_o),
      .sys_tdata_o (sys_tdata_o),
      .sys_tready_i(sys_tready_i),
      .interrupt_o (interrupt_o),
      .ctrl_en_o   (ctrl_en),
      .ctrl_mode_o (ctrl_mode),
      .ctrl_srst_o (ctrl_srst),
      .pop_o       (pop),
      .r_word_i    (r_word),
      .r_empty_i   (r_empty),
      .r_full_i    (r_full),
      .r_level_i   (r_level),
      .nbeats_i    (nbeats),
      .eof_det_i   (eof_det)
   );

endmodule

`default_nettype wire
